// ==== tests/recordMaster_testdata.txt ====
// Hex columns: bit count, 96-bit samples (first sample in bit 0), expected owTrue,
// expected word count, three expected words (unused ones zero); FFF ends the list
20 0000000000000000A5A5A5A5 0 1 A5A5A5A5 00000000 00000000
28 000000000000005AC3C3C3C3 0 2 C3C3C3C3 FFFFFF5A 00000000
40 00000000FFFFFFF81FFFFFFF 1 2 1FFFFFFF FFFFFFF8 00000000
30 000000000000FFE083FFFFFF 0 2 83FFFFFF FFFFFFE0 00000000
25 0000000000000000DEADBEEF 0 2 DEADBEEF FFFFFFE0 00000000
60 C0FFEE039ABCDEF112345678 1 3 12345678 9ABCDEF1 C0FFEE03
0 000000000000000000000000 0 0 00000000 00000000 00000000
1 000000000000000000000001 0 1 FFFFFFFF 00000000 00000000
6 000000000000000000000000 1 1 FFFFFFC0 00000000 00000000
21 000000000000000000000000 1 2 00000000 FFFFFFFE 00000000
40 0000000007FFFFFFFFFFFFFF 0 2 FFFFFFFF 07FFFFFF 00000000
FFF

// ==== files.f ====
+incdir+common
common/recTypes_pkg.sv
design/recordControl.sv
design/wordCounter.sv
recorder/sampleShifter.sv
recorder/wordStore.sv
detector/zeroRunScanner.sv
design/recordMaster.sv
tests/recordMaster_checker.sv
tests/recordMaster_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= recordMaster_tb
BUILD_DIR ?= obj_dir
FILE_LIST ?= files.f
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILE_LIST)) $(wildcard common/*.svh)
SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/recordMaster_tb.sv ====
`timescale 1ns/10ps

module recordMaster_tb;
    localparam int FIELDS = 7;              // Entries per record in the data file
    localparam int MAX_ENTRIES = 128;
    localparam int WAIT_LIMIT = 2000;

    logic clk;
    logic resetN;
    logic enable;
    logic samplePulse;
    logic dIn;
    logic cmdValid;
    recTypes_pkg::cmdOpT cmdOp;
    logic cmdReady;
    logic outValid;
    logic outReady;
    recTypes_pkg::playbackT playbackOut;
    logic owTrue;
    logic complete;
    logic [95:0] testData [MAX_ENTRIES];
    logic [31:0] lfsrState;
    int errorCount;
    int testCount;

    recordMaster DUT (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    function automatic logic nextRandomBit();
        logic outBit;
        outBit = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (outBit) begin
            lfsrState = lfsrState ^ 32'hD000_0001;     // Galois taps
        end
        return outBit;
    endfunction

    task automatic tick();
        @(posedge clk);
        #1;                                         // Just past the edge
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("Mismatch at %0t: %s expected %0h got %0h", $time, name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic waitCmdReady(input string phase);
        int cycles;
        cycles = 0;
        while (!cmdReady && cycles < WAIT_LIMIT) begin
            tick();
            cycles++;
        end
        assert (cmdReady) else begin
            $display("Timeout at %0t: cmdReady did not return after %s", $time, phase);
            errorCount++;
        end
    endtask

    task automatic recordBits(input int count, input logic [95:0] bits);
        int idle;
        enable = 1'b1;
        tick();                                     // Idle takes the rising enable
        for (int i = 0; i < count; i++) begin
            idle = 0;
            while (!nextRandomBit() && idle < 8) begin
                tick();                             // Random gap before the sample
                idle++;
            end
            samplePulse = 1'b1;
            dIn = bits[i];
            tick();
            samplePulse = 1'b0;
            tick();
        end
        enable = 1'b0;
    endtask

    task automatic sendCommand(input recTypes_pkg::cmdOpT op);
        cmdOp = op;
        cmdValid = 1'b1;
        tick();                                     // Taken while idle
        cmdValid = 1'b0;
    endtask

    task automatic runCheck(input logic expOw);
        int cycles;
        sendCommand(recTypes_pkg::opCheck);
        cycles = 0;
        while (!complete && cycles < WAIT_LIMIT) begin
            tick();
            cycles++;
        end
        assert (complete) else begin
            $display("Timeout at %0t: the check never raised complete", $time);
            errorCount++;
        end
        checkValue("owTrue", 32'(expOw), 32'(owTrue));
        checkValue("cmdReady", 32'd1, 32'(cmdReady));
    endtask

    task automatic runPlayback(input int base, input int expCount);
        int cycles;
        int got;
        sendCommand(recTypes_pkg::opPlayback);
        cycles = 0;
        got = 0;
        while (!cmdReady && cycles < WAIT_LIMIT) begin
            outReady = nextRandomBit();             // Random back-pressure
            if (outValid && outReady) begin
                if (got < expCount) begin
                    checkValue($sformatf("playbackOut.word[%0d]", got),
                               testData[base + 4 + got][31:0], playbackOut.word);
                end
                checkValue("playbackOut.last", 32'(got == expCount - 1), 32'(playbackOut.last));
                got++;
            end
            tick();
            cycles++;
        end
        outReady = 1'b0;
        assert (cmdReady) else begin
            $display("Timeout at %0t: playback did not return to idle", $time);
            errorCount++;
        end
        checkValue("played word count", expCount, got);
    endtask

    initial begin
        int base;
        int bitCount;
        int wordCount;
        int errorsBefore;
        logic expOw;
        resetN = 1'b0;
        enable = 1'b0;
        samplePulse = 1'b0;
        dIn = 1'b0;
        cmdValid = 1'b0;
        cmdOp = recTypes_pkg::opCheck;
        outReady = 1'b0;
        lfsrState = 32'h022db1a4;
        errorCount = 0;
        testCount = 0;
        $readmemh("tests/recordMaster_testdata.txt", testData);
        repeat (5) @(posedge clk);
        #1;
        resetN = 1'b1;
        checkValue("cmdReady", 32'd1, 32'(cmdReady));
        checkValue("complete", 32'd0, 32'(complete));
        checkValue("owTrue", 32'd0, 32'(owTrue));
        checkValue("outValid", 32'd0, 32'(outValid));
        for (int rec = 0; rec * FIELDS + FIELDS <= MAX_ENTRIES; rec++) begin
            base = rec * FIELDS;
            if ($isunknown(testData[base]) || testData[base] == 96'hFFF) begin
                break;                              // End marker
            end
            bitCount = testData[base][31:0];
            expOw = testData[base + 2][0];
            wordCount = testData[base + 3][31:0];
            errorsBefore = errorCount;
            recordBits(bitCount, testData[base + 1]);
            waitCmdReady("the flush");
            checkValue("owTrue after recording", 32'd0, 32'(owTrue));
            checkValue("complete after recording", 32'd0, 32'(complete));
            runCheck(expOw);
            runPlayback(base, wordCount);
            testCount++;
            $display("Test %0d: %0d bits, %0d words, owTrue %0d, %s", rec, bitCount, wordCount,
                     expOw, (errorCount == errorsBefore) ? "ok" : "errors");
        end
        if (testCount == 0) begin
            $display("No test records were read from the data file");
            errorCount++;
        end
        $display("Tests run: %0d, errors: %0d", testCount, errorCount);
        if (errorCount == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== tests/recordMaster_checker.sv ====
`timescale 1ns/10ps

module recordMaster_checker (
    input logic                   clk,
    input logic                   resetN,
    input logic                   cmdReady,
    input logic                   outValid,
    input logic                   outReady,
    input recTypes_pkg::playbackT playbackOut,
    input logic                   owTrue,
    input logic                   complete
);
    // Stalled word stays offered and unchanged
    holdWhileStalled: assert property (@(posedge clk) disable iff (!resetN)
        outValid && !outReady |=> outValid && $stable(playbackOut))
        else $error("playbackOut changed while stalled");

    cmdOrPlay: assert property (@(posedge clk) disable iff (!resetN)
        !(cmdReady && outValid))
        else $error("cmdReady and outValid high together");

    hitWithComplete: assert property (@(posedge clk) disable iff (!resetN)
        $rose(owTrue) |-> complete)
        else $error("owTrue rose without complete");

endmodule

bind recordMaster recordMaster_checker assertions (
    .clk(clk), .resetN(resetN), .cmdReady(cmdReady), .outValid(outValid),
    .outReady(outReady), .playbackOut(playbackOut), .owTrue(owTrue), .complete(complete)
);

// ==== design/recordMaster.sv ====
`timescale 1ns/10ps

module recordMaster (
    input  logic                   clk,
    input  logic                   resetN,
    input  logic                   enable,
    input  logic                   samplePulse,
    input  logic                   dIn,
    input  logic                   cmdValid,
    input  recTypes_pkg::cmdOpT    cmdOp,
    output logic                   cmdReady,
    output logic                   outValid,
    input  logic                   outReady,
    output recTypes_pkg::playbackT playbackOut,
    output logic                   owTrue,
    output logic                   complete
);
    recTypes_pkg::recWordT wordData;
    recTypes_pkg::recWordT readWord;
    recTypes_pkg::recAddrT wordAddr;
    recTypes_pkg::recAddrT readIndex;

    logic wordWrite;
    logic storeWrite;
    logic flushDone;
    logic captureOn;
    logic flush;
    logic clearCount;
    logic clearIndex;
    logic advanceIndex;
    logic scanAdvance;
    logic scanStart;
    logic scanDone;
    logic lastRead;
    logic countEmpty;
    logic countFull;

    assign storeWrite = wordWrite && !countFull;    // Drop words past the store

    assign playbackOut.word = readWord;
    assign playbackOut.last = lastRead;

    recordControl control (
        .clk, .resetN, .enable, .cmdValid, .cmdOp, .cmdReady,
        .flushDone, .scanDone, .countEmpty, .lastRead, .outReady,
        .captureOn, .flush, .clearCount, .clearIndex, .advanceIndex,
        .scanStart, .outValid
    );

    wordCounter counter (
        .clk, .resetN, .clearCount, .wordWrite, .clearIndex,
        .advanceIndex(advanceIndex || scanAdvance),  // Playback or scan step
        .readIndex, .lastRead, .countEmpty, .countFull, .wordAddr
    );

    sampleShifter shifter (
        .clk, .resetN, .captureOn, .flush, .samplePulse, .dIn,
        .wordWrite, .wordData, .flushDone
    );

    wordStore store (
        .clk, .wordWrite(storeWrite), .wordAddr, .wordData,
        .readIndex, .readWord
    );

    zeroRunScanner scanner (
        .clk, .resetN, .clearCount, .scanStart, .readWord, .lastRead,
        .countEmpty, .scanAdvance, .scanDone, .owTrue, .complete
    );

endmodule

// ==== detector/zeroRunScanner.sv ====
`timescale 1ns/10ps
`include "rec_macros.svh"

module zeroRunScanner (
    input  logic                  clk,
    input  logic                  resetN,
    input  logic                  clearCount,
    input  logic                  scanStart,
    input  recTypes_pkg::recWordT readWord,
    input  logic                  lastRead,
    input  logic                  countEmpty,
    output logic                  scanAdvance,
    output logic                  scanDone,
    output logic                  owTrue,
    output logic                  complete
);
    localparam int RUN_BITS = $clog2(`REC_ZERO_RUN + 1);

    recTypes_pkg::recWordT  shiftReg;
    recTypes_pkg::bitIndexT bitsLeft;
    logic [RUN_BITS-1:0] runLen;        // Carries across word boundaries
    logic active;
    logic readWait;                     // First read still in flight
    logic finalWord;
    logic load;
    logic shifting;
    logic hit;

    assign load     = active && !readWait && !countEmpty && (bitsLeft == '0);
    assign shifting = active && (bitsLeft != '0);
    assign hit      = shifting && !shiftReg[0] && (runLen == RUN_BITS'(`REC_ZERO_RUN - 1));
    assign scanDone = active && (countEmpty || hit
                      || (shifting && finalWord && (bitsLeft == recTypes_pkg::bitIndexT'(1))));
    assign scanAdvance = load && !lastRead;     // Prefetch the next word

    always_ff @(posedge clk) begin
        if (!resetN) begin
            active   <= 1'b0;
            readWait <= 1'b0;
            bitsLeft <= '0;
            runLen   <= '0;
        end else if (scanStart) begin
            active   <= 1'b1;
            readWait <= 1'b1;
            bitsLeft <= '0;
            runLen   <= '0;
        end else if (scanDone) begin
            active   <= 1'b0;
            readWait <= 1'b0;
            bitsLeft <= '0;
        end else if (active) begin
            readWait <= 1'b0;
            if (load) begin
                bitsLeft <= recTypes_pkg::bitIndexT'(`REC_WORD_BITS);
            end else if (shifting) begin
                bitsLeft <= bitsLeft - recTypes_pkg::bitIndexT'(1);
                runLen   <= shiftReg[0] ? '0 : runLen + RUN_BITS'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            shiftReg  <= readWord;
            finalWord <= lastRead;
        end else if (shifting) begin
            shiftReg <= shiftReg >> 1;      // Bit 0 is the oldest sample
        end
    end

    // Status, cleared by a fresh recording or a new check
    always_ff @(posedge clk) begin
        if (!resetN || clearCount || scanStart) begin
            owTrue   <= 1'b0;
            complete <= 1'b0;
        end else if (scanDone) begin
            owTrue   <= hit;
            complete <= 1'b1;
        end
    end

endmodule

// ==== recorder/wordStore.sv ====
`timescale 1ns/10ps
`include "rec_macros.svh"

module wordStore (
    input  logic                  clk,
    input  logic                  wordWrite,
    input  recTypes_pkg::recAddrT wordAddr,
    input  recTypes_pkg::recWordT wordData,
    input  recTypes_pkg::recAddrT readIndex,
    output recTypes_pkg::recWordT readWord
);
    recTypes_pkg::recWordT mem [`REC_DEPTH];

    always_ff @(posedge clk) begin
        if (wordWrite) begin
            mem[wordAddr] <= wordData;
        end
    end

    // Registered read, data one cycle after the index
    always_ff @(posedge clk) begin
        readWord <= mem[readIndex];
    end

endmodule

// ==== recorder/sampleShifter.sv ====
`timescale 1ns/10ps
`include "rec_macros.svh"

module sampleShifter (
    input  logic                  clk,
    input  logic                  resetN,
    input  logic                  captureOn,
    input  logic                  flush,
    input  logic                  samplePulse,
    input  logic                  dIn,
    output logic                  wordWrite,
    output recTypes_pkg::recWordT wordData,
    output logic                  flushDone
);
    recTypes_pkg::bitIndexT fill;       // Bits held in the word
    recTypes_pkg::bitIndexT fillBase;
    logic capture;
    logic padding;

    assign capture   = captureOn && samplePulse;
    assign wordWrite = (fill == recTypes_pkg::bitIndexT'(`REC_WORD_BITS));
    assign fillBase  = wordWrite ? '0 : fill;     // Full word leaves this cycle
    assign padding   = flush && (fill != '0) && !wordWrite;

    // Empty flush ends at once, otherwise with the padded write
    assign flushDone = flush && ((fill == '0) || wordWrite);

    always_ff @(posedge clk) begin
        if (!resetN) begin
            fill <= '0;
        end else if (capture) begin
            fill <= fillBase + recTypes_pkg::bitIndexT'(1);
        end else if (padding) begin
            fill <= fill + recTypes_pkg::bitIndexT'(1);
        end else if (wordWrite) begin
            fill <= '0;
        end
    end

    // New bits enter at the top so the first sample ends in bit 0
    always_ff @(posedge clk) begin
        if (capture) begin
            wordData <= {dIn, wordData[`REC_WORD_BITS-1:1]};
        end else if (padding) begin
            wordData <= {1'b1, wordData[`REC_WORD_BITS-1:1]};   // Pad with ones
        end
    end

endmodule

// ==== design/wordCounter.sv ====
`timescale 1ns/10ps
`include "rec_macros.svh"

module wordCounter (
    input  logic                  clk,
    input  logic                  resetN,
    input  logic                  clearCount,
    input  logic                  wordWrite,
    input  logic                  clearIndex,
    input  logic                  advanceIndex,
    output recTypes_pkg::recAddrT readIndex,
    output logic                  lastRead,
    output logic                  countEmpty,
    output logic                  countFull,
    output recTypes_pkg::recAddrT wordAddr
);
    recTypes_pkg::recCountT wordCount;

    // Saturating count of stored words
    always_ff @(posedge clk) begin
        if (!resetN || clearCount) begin
            wordCount <= '0;
        end else if (wordWrite && !countFull) begin
            wordCount <= wordCount + recTypes_pkg::recCountT'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (!resetN || clearIndex) begin
            readIndex <= '0;
        end else if (advanceIndex) begin
            readIndex <= readIndex + recTypes_pkg::recAddrT'(1);
        end
    end

    assign wordAddr   = wordCount[$bits(recTypes_pkg::recAddrT)-1:0];  // Next free slot
    assign countEmpty = (wordCount == '0);
    assign countFull  = (wordCount == recTypes_pkg::recCountT'(`REC_DEPTH));
    assign lastRead   = (recTypes_pkg::recCountT'(readIndex) + recTypes_pkg::recCountT'(1))
                        == wordCount;

endmodule

// ==== design/recordControl.sv ====
`timescale 1ns/10ps

module recordControl (
    input  logic                clk,
    input  logic                resetN,
    input  logic                enable,
    input  logic                cmdValid,
    input  recTypes_pkg::cmdOpT cmdOp,
    output logic                cmdReady,
    input  logic                flushDone,
    input  logic                scanDone,
    input  logic                countEmpty,
    input  logic                lastRead,
    input  logic                outReady,
    output logic                captureOn,
    output logic                flush,
    output logic                clearCount,
    output logic                clearIndex,
    output logic                advanceIndex,
    output logic                scanStart,
    output logic                outValid
);
    recTypes_pkg::recStateT state;
    recTypes_pkg::recStateT nextState;
    logic cmdTaken;

    // Commands only while idle with recording off
    assign cmdReady = (state == recTypes_pkg::sIdle) && !enable;
    assign cmdTaken = cmdReady && cmdValid;

    always_ff @(posedge clk) begin
        if (!resetN) begin
            state <= recTypes_pkg::sIdle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState    = state;
        captureOn    = 1'b0;
        flush        = 1'b0;
        clearCount   = 1'b0;
        clearIndex   = 1'b0;
        advanceIndex = 1'b0;
        scanStart    = 1'b0;
        outValid     = 1'b0;
        unique case (state)
            recTypes_pkg::sIdle: begin
                if (enable) begin
                    clearCount = 1'b1;                  // Fresh recording
                    nextState  = recTypes_pkg::sRecord;
                end else if (cmdTaken) begin
                    clearIndex = 1'b1;
                    if (cmdOp == recTypes_pkg::opCheck) begin
                        scanStart = 1'b1;
                        nextState = recTypes_pkg::sScan;
                    end else if (!countEmpty) begin
                        nextState = recTypes_pkg::sPlayLoad;
                    end
                end
            end
            recTypes_pkg::sRecord: begin
                captureOn = enable;
                if (!enable) begin
                    nextState = recTypes_pkg::sFlush;
                end
            end
            recTypes_pkg::sFlush: begin
                flush = 1'b1;
                if (flushDone) begin
                    nextState = recTypes_pkg::sIdle;
                end
            end
            recTypes_pkg::sScan: begin
                if (scanDone) begin
                    nextState = recTypes_pkg::sIdle;
                end
            end
            recTypes_pkg::sPlayLoad: begin
                nextState = recTypes_pkg::sPlay;        // Store read in flight
            end
            recTypes_pkg::sPlay: begin
                outValid = 1'b1;
                if (outReady) begin
                    advanceIndex = 1'b1;
                    if (lastRead) begin
                        nextState = recTypes_pkg::sIdle;
                    end else begin
                        nextState = recTypes_pkg::sPlayLoad;
                    end
                end
            end
            default: begin
                nextState = recTypes_pkg::sIdle;
            end
        endcase
    end

endmodule

// ==== common/recTypes_pkg.sv ====
`include "rec_macros.svh"

package recTypes_pkg;

    typedef logic [`REC_WORD_BITS-1:0] recWordT;
    typedef logic [$clog2(`REC_DEPTH)-1:0] recAddrT;
    typedef logic [$clog2(`REC_DEPTH):0] recCountT;    // 0 to REC_DEPTH
    typedef logic [5:0] bitIndexT;                      // 0 to 32

    typedef enum logic {
        opCheck,
        opPlayback
    } cmdOpT;

    typedef enum logic [2:0] {
        sIdle,
        sRecord,
        sFlush,
        sScan,
        sPlayLoad,
        sPlay
    } recStateT;

    typedef struct packed {
        recWordT word;
        logic    last;      // Final stored word
    } playbackT;

endpackage

// ==== common/rec_macros.svh ====
`ifndef REC_MACROS_SVH
`define REC_MACROS_SVH

// Recorder sizing
`define REC_WORD_BITS 32    // Bits per stored word
`define REC_DEPTH 16        // Words in the store
`define REC_ZERO_RUN 6      // Zero run that flags a hit

`endif
